/* Bender.yml */
package:
  name: graph_algorithm_control

export_include_dirs:
  - .

sources:
  - graph_pkg.sv
  - cu_bus_if.sv
  - request_buffer.sv
  - vertex_rank_cu.sv
  - cu_arbiter_control.sv
  - graph_algorithm_control.sv
  - target: test
    files:
      - tb_graph_algorithm_control.sv

/* cu_arbiter_control.sv */
// Arbiter and control for the compute units
// Enable register, job dispatch, round-robin read and write merging,
// response routing by tag, done counters

`timescale 1ns/10ps

`include "graph_defines.svh"

module cu_arbiter_control (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enabled_in,
	cu_bus_if.arbiter                      bus [`NUM_CU],
	input  logic                           vertex_job_valid,
	input  graph_pkg::vertex_job_t         vertex_job,
	output logic                           vertex_job_request,
	input  logic                           read_response_valid,
	input  graph_pkg::read_response_t      read_response,
	output logic                           read_push,
	output graph_pkg::read_command_t       read_push_data,
	input  logic                           read_full,
	output logic                           write_push,
	output graph_pkg::edge_data_write_t    write_push_data,
	input  logic                           write_full,
	input  logic                           write_pop,
	output logic [`COUNTER_BITS-1:0]       vertex_job_counter_done,
	output logic [`COUNTER_BITS-1:0]       edge_job_counter_done
);
	import graph_pkg::*;

	logic                  enabled;
	logic [`NUM_CU-1:0]    job_request;
	logic [`NUM_CU-1:0]    job_free;
	logic [`NUM_CU-1:0]    job_valid_q;
	logic [`NUM_CU-1:0]    read_valid;
	logic [`NUM_CU-1:0]    read_ready;
	logic [`NUM_CU-1:0]    read_grant_q;
	logic [`NUM_CU-1:0]    write_valid;
	logic [`NUM_CU-1:0]    write_ready;
	logic [`NUM_CU-1:0]    write_grant_q;
	logic [`NUM_CU-1:0]    response_valid_q;
	logic [`DATA_BITS-1:0] response_data_q;
	read_command_t         read_command [`NUM_CU];
	edge_data_write_t      write_record [`NUM_CU];
	vertex_job_t           job_q;
	cu_id_t                job_sel;
	cu_id_t                read_sel;
	cu_id_t                write_sel;
	cu_id_t                read_rr;
	cu_id_t                write_rr;

	// First set request at or after start, wrapping around
	function automatic cu_id_t rr_pick(input logic [`NUM_CU-1:0] req, input cu_id_t start);
		cu_id_t idx;
		rr_pick = start;
		for (int k = `NUM_CU - 1; k >= 0; k--) begin
			idx = cu_id_t'(start + k);
			if (req[idx]) begin
				rr_pick = idx;
			end
		end
	endfunction

	generate
		for (genvar g = 0; g < `NUM_CU; g++) begin : g_bus
			assign job_request[g]        = bus[g].job_request;
			assign read_valid[g]         = bus[g].read_valid;
			assign read_command[g]       = bus[g].read_command;
			assign write_valid[g]        = bus[g].write_valid;
			assign write_record[g]       = bus[g].write_record;
			assign bus[g].job_valid      = job_valid_q[g];
			assign bus[g].job            = job_q;
			assign bus[g].read_grant     = read_grant_q[g];
			assign bus[g].response_valid = response_valid_q[g];
			assign bus[g].response_data  = response_data_q;
			assign bus[g].write_grant    = write_grant_q[g];
		end
	endgenerate

	////////////////////////////////////////////////////////////////////////////
	// Selection
	////////////////////////////////////////////////////////////////////////////

	// A unit served last cycle still shows its old request
	assign job_free    = job_request & ~job_valid_q;
	assign read_ready  = read_valid & ~read_grant_q;
	assign write_ready = write_valid & ~write_grant_q;

	assign vertex_job_request = enabled && (|job_free);
	assign job_sel            = rr_pick(job_free, '0);
	assign read_sel           = rr_pick(read_ready, read_rr);
	assign write_sel          = rr_pick(write_ready, write_rr);

	assign read_push       = enabled && !read_full && (|read_ready);
	assign read_push_data  = read_command[read_sel];
	assign write_push      = enabled && !write_full && (|write_ready);
	assign write_push_data = write_record[write_sel];

	////////////////////////////////////////////////////////////////////////////
	// Strobes, pointers and counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled                 <= 1'b0;
			job_valid_q             <= '0;
			read_grant_q            <= '0;
			write_grant_q           <= '0;
			response_valid_q        <= '0;
			read_rr                 <= '0;
			write_rr                <= '0;
			vertex_job_counter_done <= '0;
			edge_job_counter_done   <= '0;
		end else begin
			enabled          <= enabled_in;
			job_valid_q      <= '0;
			read_grant_q     <= '0;
			write_grant_q    <= '0;
			response_valid_q <= '0;
			if (vertex_job_request && vertex_job_valid) begin
				job_valid_q[job_sel] <= 1'b1;
			end
			if (read_push) begin
				read_grant_q[read_sel] <= 1'b1;
				read_rr                <= read_sel + 1'b1;
			end
			if (write_push) begin
				write_grant_q[write_sel] <= 1'b1;
				write_rr                 <= write_sel + 1'b1;
			end
			// Route by tag
			if (enabled && read_response_valid) begin
				response_valid_q[read_response.tag] <= 1'b1;
				edge_job_counter_done               <= edge_job_counter_done + 1'b1;
			end
			if (write_pop) begin
				vertex_job_counter_done <= vertex_job_counter_done + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (vertex_job_request && vertex_job_valid) begin
			job_q <= vertex_job;
		end
		if (read_response_valid) begin
			response_data_q <= read_response.data;
		end
	end

	// A response must belong to a unit with a job in flight
	assert property (@(posedge clock) disable iff (!rstn)
		(enabled && read_response_valid) |-> !job_request[read_response.tag]);

endmodule

/* cu_bus_if.sv */
// Bus between the arbiter and one compute unit
// Job dispatch, edge reads, routed responses and write records

`timescale 1ns/10ps

`include "graph_defines.svh"

interface cu_bus_if;
	import graph_pkg::*;

	logic                  job_request;
	logic                  job_valid;
	vertex_job_t           job;
	logic                  read_valid;
	read_command_t         read_command;
	logic                  read_grant;
	logic                  response_valid;
	logic [`DATA_BITS-1:0] response_data;
	logic                  write_valid;
	edge_data_write_t      write_record;
	logic                  write_grant;

	modport cu (
		output job_request, read_valid, read_command, write_valid, write_record,
		input  job_valid, job, read_grant, response_valid, response_data, write_grant
	);

	modport arbiter (
		input  job_request, read_valid, read_command, write_valid, write_record,
		output job_valid, job, read_grant, response_valid, response_data, write_grant
	);

endinterface

/* flist.f */
+incdir+.
graph_pkg.sv
cu_bus_if.sv
request_buffer.sv
vertex_rank_cu.sv
cu_arbiter_control.sv
graph_algorithm_control.sv
tb_graph_algorithm_control.sv

/* graph_algorithm_control.sv */
// Top level of the graph control block
// Compute units, arbiter, read command and write record buffers

`timescale 1ns/10ps

`include "graph_defines.svh"

module graph_algorithm_control (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled_in,
	input  logic                        vertex_job_valid,
	input  logic [`VERTEX_BITS-1:0]     vertex_job_id,
	input  logic [`EDGE_INDEX_BITS-1:0] vertex_job_edge_start,
	input  logic [`DEGREE_BITS-1:0]     vertex_job_degree,
	output logic                        vertex_job_request,
	output logic                        read_command_valid,
	output logic [`EDGE_INDEX_BITS-1:0] read_command_address,
	output graph_pkg::cu_id_t           read_command_tag,
	input  logic                        read_command_grant,
	input  logic                        read_response_valid,
	input  logic [`DATA_BITS-1:0]       read_response_data,
	input  graph_pkg::cu_id_t           read_response_tag,
	output logic                        write_command_valid,
	output logic [`VERTEX_BITS-1:0]     write_command_vertex,
	output logic [`DATA_BITS-1:0]       write_command_data,
	input  logic                        write_command_grant,
	output logic [`COUNTER_BITS-1:0]    vertex_job_counter_done,
	output logic [`COUNTER_BITS-1:0]    edge_job_counter_done
);
	import graph_pkg::*;

	vertex_job_t      vertex_job;
	read_response_t   read_response;
	read_command_t    read_push_data;
	read_command_t    read_pop_data;
	edge_data_write_t write_push_data;
	edge_data_write_t write_pop_data;
	logic             read_push;
	logic             read_pop;
	logic             read_full;
	logic             read_empty;
	logic             write_push;
	logic             write_pop;
	logic             write_full;
	logic             write_empty;

	cu_bus_if cu_bus [`NUM_CU] ();

	assign vertex_job    = '{vertex_id: vertex_job_id, edge_start: vertex_job_edge_start,
	                         degree: vertex_job_degree};
	assign read_response = '{data: read_response_data, tag: read_response_tag};

	////////////////////////////////////////////////////////////////////////////
	// Compute units and arbiter
	////////////////////////////////////////////////////////////////////////////

	generate
		for (genvar g = 0; g < `NUM_CU; g++) begin : g_cu
			vertex_rank_cu #(.CU_ID(cu_id_t'(g))) i_cu (
				.clock  (clock),
				.rstn   (rstn),
				.enabled(enabled_in),
				.bus    (cu_bus[g])
			);
		end
	endgenerate

	cu_arbiter_control i_arbiter (
		.clock                  (clock),
		.rstn                   (rstn),
		.enabled_in             (enabled_in),
		.bus                    (cu_bus),
		.vertex_job_valid       (vertex_job_valid),
		.vertex_job             (vertex_job),
		.vertex_job_request     (vertex_job_request),
		.read_response_valid    (read_response_valid),
		.read_response          (read_response),
		.read_push              (read_push),
		.read_push_data         (read_push_data),
		.read_full              (read_full),
		.write_push             (write_push),
		.write_push_data        (write_push_data),
		.write_full             (write_full),
		.write_pop              (write_pop),
		.vertex_job_counter_done(vertex_job_counter_done),
		.edge_job_counter_done  (edge_job_counter_done)
	);

	////////////////////////////////////////////////////////////////////////////
	// Output buffers
	////////////////////////////////////////////////////////////////////////////

	request_buffer #(.payload_t(read_command_t)) i_read_buffer (
		.clock    (clock),
		.rstn     (rstn),
		.push     (read_push),
		.push_data(read_push_data),
		.full     (read_full),
		.pop      (read_pop),
		.pop_data (read_pop_data),
		.empty    (read_empty)
	);

	request_buffer #(.payload_t(edge_data_write_t)) i_write_buffer (
		.clock    (clock),
		.rstn     (rstn),
		.push     (write_push),
		.push_data(write_push_data),
		.full     (write_full),
		.pop      (write_pop),
		.pop_data (write_pop_data),
		.empty    (write_empty)
	);

	assign read_command_valid   = !read_empty;
	assign read_pop             = read_command_grant && !read_empty;
	assign read_command_address = read_pop_data.address;
	assign read_command_tag     = read_pop_data.tag;

	assign write_command_valid  = !write_empty;
	assign write_pop            = write_command_grant && !write_empty;
	assign write_command_vertex = write_pop_data.vertex_id;
	assign write_command_data   = write_pop_data.rank_sum;

endmodule

/* graph_defines.svh */
// Field widths, unit count and buffer depth for the graph control block
// Shared by the package and the RTL modules

`ifndef GRAPH_DEFINES_SVH
`define GRAPH_DEFINES_SVH

// Compute units and request buffers
`define NUM_CU          4
`define BUFFER_DEPTH    4

// Field widths
`define VERTEX_BITS     16
`define EDGE_INDEX_BITS 32
`define DEGREE_BITS     8
`define DATA_BITS       32
`define COUNTER_BITS    32

`endif

/* graph_pkg.sv */
// Types shared by the graph control block
// Vertex job, edge read command and response, edge data write record

`include "graph_defines.svh"

package graph_pkg;

	// Unit index, also used as the read tag
	typedef logic [$clog2(`NUM_CU)-1:0] cu_id_t;

	// Job as delivered from the vertex source
	typedef struct packed {
		logic [`VERTEX_BITS-1:0]     vertex_id;
		logic [`EDGE_INDEX_BITS-1:0] edge_start;
		logic [`DEGREE_BITS-1:0]     degree;
	} vertex_job_t;

	// One edge read toward memory
	typedef struct packed {
		logic [`EDGE_INDEX_BITS-1:0] address;
		cu_id_t                      tag;
	} read_command_t;

	typedef struct packed {
		logic [`DATA_BITS-1:0] data;
		cu_id_t                tag;
	} read_response_t;

	// Result of one vertex
	typedef struct packed {
		logic [`VERTEX_BITS-1:0] vertex_id;
		logic [`DATA_BITS-1:0]   rank_sum;
	} edge_data_write_t;

endpackage

/* request_buffer.sv */
// Synchronous FIFO with show-ahead output
// Holds read commands or write records on their way out

`timescale 1ns/10ps

`include "graph_defines.svh"

module request_buffer #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     push,
	input  payload_t push_data,
	output logic     full,
	input  logic     pop,
	output payload_t pop_data,
	output logic     empty
);

	localparam int PTR_BITS = $clog2(`BUFFER_DEPTH);

	// Extra wrap bit tells full from empty
	logic [PTR_BITS:0] write_ptr;
	logic [PTR_BITS:0] read_ptr;
	payload_t          mem [`BUFFER_DEPTH];

	assign empty = (write_ptr == read_ptr);
	assign full  = (write_ptr[PTR_BITS] != read_ptr[PTR_BITS]) &&
	               (write_ptr[PTR_BITS-1:0] == read_ptr[PTR_BITS-1:0]);

	// Head entry is visible whenever the buffer holds data
	assign pop_data = mem[read_ptr[PTR_BITS-1:0]];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_ptr <= '0;
			read_ptr  <= '0;
		end else begin
			if (push && !full) begin
				write_ptr <= write_ptr + 1'b1;
			end
			if (pop && !empty) begin
				read_ptr <= read_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (push && !full) begin
			mem[write_ptr[PTR_BITS-1:0]] <= push_data;
		end
	end

	assert property (@(posedge clock) disable iff (!rstn) push |-> !full);
	assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty);

endmodule

/* tb_graph_algorithm_control.sv */
// Testbench for the graph control block
// Memory model with shuffled responses, write record scoreboard,
// directed tests for dispatch, back-pressure and enable

`timescale 1ns/10ps

`include "graph_defines.svh"

module tb_graph_algorithm_control;
	import graph_pkg::*;

	logic                        clock;
	logic                        rstn;
	logic                        enabled_in;
	logic                        vertex_job_valid;
	logic [`VERTEX_BITS-1:0]     vertex_job_id;
	logic [`EDGE_INDEX_BITS-1:0] vertex_job_edge_start;
	logic [`DEGREE_BITS-1:0]     vertex_job_degree;
	logic                        vertex_job_request;
	logic                        read_command_valid;
	logic [`EDGE_INDEX_BITS-1:0] read_command_address;
	cu_id_t                      read_command_tag;
	logic                        read_command_grant = 1'b0;
	logic                        read_response_valid = 1'b0;
	logic [`DATA_BITS-1:0]       read_response_data = '0;
	cu_id_t                      read_response_tag = '0;
	logic                        write_command_valid;
	logic [`VERTEX_BITS-1:0]     write_command_vertex;
	logic [`DATA_BITS-1:0]       write_command_data;
	logic                        write_command_grant;
	logic [`COUNTER_BITS-1:0]    vertex_job_counter_done;
	logic [`COUNTER_BITS-1:0]    edge_job_counter_done;

	int                 errors = 0;
	int                 checks = 0;
	int                 cycles = 0;
	int                 cycle_limit = 2000;
	int                 job_count = 0;
	int                 total_edges = 0;
	int                 total_reads = 0;
	int                 records_received = 0;
	logic [`NUM_CU-1:0] tag_mask = '0;
	logic [31:0]        expected_sum [int];
	bit                 record_seen [int];
	int                 read_count [logic [31:0]];
	logic [31:0]        job_start [$];
	int                 job_degree [$];
	logic [31:0]        pending_address [$];
	cu_id_t             pending_tag [$];
	int                 random_degree [20];

	graph_algorithm_control i_dut (.*);

	always #5 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// Reference rule, checks and job driver
	////////////////////////////////////////////////////////////////////////////

	// Memory content of one edge
	function automatic logic [31:0] edge_data(input logic [31:0] address);
		return address * 32'd3 + 32'd1;
	endfunction

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %0t: %s: got %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	// Jobs get disjoint edge ranges near the top of the address space
	task automatic offer_job(input int degree);
		logic [31:0] start;
		logic [31:0] sum;
		logic        accepted;
		start = 32'hFFFF_FE00 + 32'(job_count) * 32'd16;
		sum   = '0;
		for (int k = 0; k < degree; k++) begin
			sum = sum + edge_data(start + 32'(k));
		end
		expected_sum[job_count] = sum;
		job_start.push_back(start);
		job_degree.push_back(degree);
		total_edges += degree;
		vertex_job_id         = `VERTEX_BITS'(job_count);
		vertex_job_edge_start = start;
		vertex_job_degree     = `DEGREE_BITS'(degree);
		vertex_job_valid      = 1'b1;
		do begin
			@(posedge clock);
			accepted = vertex_job_request;
			#1;
		end while (!accepted);
		vertex_job_valid = 1'b0;
		job_count++;
	endtask

	task automatic wait_records(input int count);
		while (records_received < count) begin
			@(posedge clock);
			#1;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Memory model, write scoreboard and timeout
	////////////////////////////////////////////////////////////////////////////

	// Responses only while the registered enable will accept them
	always @(posedge clock) begin
		int   pick;
		logic respond;
		respond = 1'b0;
		pick    = 0;
		if (rstn && read_command_valid && read_command_grant) begin
			pending_address.push_back(read_command_address);
			pending_tag.push_back(read_command_tag);
			if (read_count.exists(read_command_address))
				read_count[read_command_address]++;
			else
				read_count[read_command_address] = 1;
			total_reads++;
			tag_mask[read_command_tag] = 1'b1;
		end
		if (rstn && enabled_in && pending_address.size() > 0 && $urandom_range(2) != 0) begin
			respond = 1'b1;
			pick    = $urandom_range(pending_address.size() - 1);
		end
		#1;
		read_response_valid = respond;
		if (respond) begin
			read_response_data = edge_data(pending_address[pick]);
			read_response_tag  = pending_tag[pick];
			pending_address.delete(pick);
			pending_tag.delete(pick);
		end
		read_command_grant = ($urandom_range(3) != 0);
	end

	always @(posedge clock) begin
		if (rstn && write_command_valid && write_command_grant) begin
			if (!expected_sum.exists(int'(write_command_vertex)) ||
			    record_seen.exists(int'(write_command_vertex))) begin
				errors++;
				$display("Unexpected write record for vertex %0d at %0t",
				         write_command_vertex, $time);
			end else begin
				check_value(write_command_data, expected_sum[int'(write_command_vertex)],
				            "rank sum");
				record_seen[int'(write_command_vertex)] = 1'b1;
			end
			records_received++;
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset();
		@(posedge clock);
		check_value(vertex_job_request, 0, "vertex_job_request after reset");
		check_value(read_command_valid, 0, "read_command_valid after reset");
		check_value(write_command_valid, 0, "write_command_valid after reset");
		check_value(vertex_job_counter_done, 0, "vertex counter after reset");
		check_value(edge_job_counter_done, 0, "edge counter after reset");
		#1;
		enabled_in          = 1'b1;
		write_command_grant = 1'b1;
		for (int n = 0; n < 4 && !vertex_job_request; n++) begin
			@(posedge clock);
			#1;
		end
		check_value(vertex_job_request, 1, "vertex_job_request after enable");
	endtask

	task automatic test_single_jobs();
		offer_job(5);
		wait_records(job_count);
		// Isolated vertex
		offer_job(0);
		wait_records(job_count);
	endtask

	task automatic test_random_jobs();
		foreach (random_degree[i]) begin
			offer_job(random_degree[i]);
		end
		wait_records(job_count);
		check_value($countones(tag_mask) > 1, 1, "more than one unit issued reads");
	endtask

	// Four records fill the buffer, four more stay in the units
	task automatic test_write_backpressure();
		logic [`VERTEX_BITS-1:0] held_vertex;
		logic [`DATA_BITS-1:0]   held_data;
		write_command_grant = 1'b0;
		for (int i = 0; i < 8; i++) begin
			offer_job(3);
		end
		while (!write_command_valid) begin
			@(posedge clock);
			#1;
		end
		held_vertex = write_command_vertex;
		held_data   = write_command_data;
		do begin
			@(posedge clock);
			check_value(write_command_valid, 1, "write_command_valid held");
			check_value(write_command_vertex, held_vertex, "held write vertex");
			check_value(write_command_data, held_data, "held write data");
			#1;
		end while (edge_job_counter_done != total_edges);
		repeat (3) begin
			@(posedge clock);
			#1;
		end
		check_value(vertex_job_request, 0, "vertex_job_request under back-pressure");
		write_command_grant = 1'b1;
		wait_records(job_count);
	endtask

	task automatic test_disable();
		logic [`COUNTER_BITS-1:0] vertex_before;
		logic [`COUNTER_BITS-1:0] edge_before;
		enabled_in = 1'b0;
		@(posedge clock);
		#1;
		vertex_before         = vertex_job_counter_done;
		edge_before           = edge_job_counter_done;
		vertex_job_id         = 16'h7FFF;
		vertex_job_edge_start = '0;
		vertex_job_degree     = 8'd4;
		vertex_job_valid      = 1'b1;
		repeat (20) begin
			@(posedge clock);
			check_value(vertex_job_request, 0, "vertex_job_request while disabled");
			check_value(read_command_valid, 0, "read_command_valid while disabled");
			check_value(vertex_job_counter_done, vertex_before, "vertex counter disabled");
			check_value(edge_job_counter_done, edge_before, "edge counter disabled");
			#1;
		end
		vertex_job_valid = 1'b0;
		enabled_in       = 1'b1;
		for (int i = 0; i < 4; i++) begin
			offer_job(4);
		end
		wait_records(job_count);
	endtask

	task automatic test_final_counts();
		logic [31:0] address;
		check_value(vertex_job_counter_done, job_count, "vertex_job_counter_done");
		check_value(edge_job_counter_done, total_edges, "edge_job_counter_done");
		check_value(total_reads, total_edges, "read commands issued");
		foreach (job_start[j]) begin
			for (int k = 0; k < job_degree[j]; k++) begin
				address = job_start[j] + 32'(k);
				check_value(read_count.exists(address) ? read_count[address] : 0, 1,
				            "reads of one edge address");
			end
		end
	endtask

	initial begin
		void'($urandom(69025));
		clock                 = 1'b0;
		rstn                  = 1'b0;
		enabled_in            = 1'b0;
		vertex_job_valid      = 1'b0;
		vertex_job_id         = '0;
		vertex_job_edge_start = '0;
		vertex_job_degree     = '0;
		write_command_grant   = 1'b0;
		// Fixed tests use 45 edges
		cycle_limit = cycle_limit + 20 * 45;
		foreach (random_degree[i]) begin
			random_degree[i] = $urandom_range(12);
			cycle_limit      = cycle_limit + 20 * random_degree[i];
		end
		repeat (10) @(posedge clock);
		#1;
		rstn = 1'b1;
		test_reset();
		test_single_jobs();
		test_random_jobs();
		test_write_backpressure();
		test_disable();
		test_final_counts();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* vertex_rank_cu.sv */
// Vertex compute unit
// Expands one vertex job into edge reads and sums the returned data

`timescale 1ns/10ps

`include "graph_defines.svh"

module vertex_rank_cu #(
	parameter graph_pkg::cu_id_t CU_ID = '0
) (
	input logic  clock,
	input logic  rstn,
	input logic  enabled,
	cu_bus_if.cu bus
);
	import graph_pkg::*;

	typedef enum logic [1:0] {
		state_idle,
		state_reading,
		state_writing
	} cu_state_t;

	cu_state_t               state;
	vertex_job_t             job;
	logic [`DEGREE_BITS-1:0] issue_count;
	logic [`DEGREE_BITS-1:0] response_count;
	logic [`DATA_BITS-1:0]   rank_sum;

	////////////////////////////////////////////////////////////////////////////
	// Bus outputs
	////////////////////////////////////////////////////////////////////////////

	assign bus.job_request = enabled && (state == state_idle);

	// One read per edge, at consecutive edge indices
	assign bus.read_valid   = enabled && (state == state_reading) && (issue_count < job.degree);
	assign bus.read_command = '{
		address: job.edge_start + `EDGE_INDEX_BITS'(issue_count),
		tag:     CU_ID
	};

	assign bus.write_valid  = enabled && (state == state_writing);
	assign bus.write_record = '{vertex_id: job.vertex_id, rank_sum: rank_sum};

	////////////////////////////////////////////////////////////////////////////
	// FSM and edge counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state          <= state_idle;
			issue_count    <= '0;
			response_count <= '0;
		end else begin
			case (state)
				state_idle: begin
					if (bus.job_valid) begin
						issue_count    <= '0;
						response_count <= '0;
						// Nothing to read for an isolated vertex
						state <= (bus.job.degree == '0) ? state_writing : state_reading;
					end
				end
				state_reading: begin
					if (bus.read_grant) begin
						issue_count <= issue_count + 1'b1;
					end
					// Responses may come back in any order
					if (bus.response_valid) begin
						response_count <= response_count + 1'b1;
						if (response_count + 1'b1 == job.degree) begin
							state <= state_writing;
						end
					end
				end
				state_writing: begin
					if (bus.write_grant) begin
						state <= state_idle;
					end
				end
				default: state <= state_idle;
			endcase
		end
	end

	// Job and running sum
	always_ff @(posedge clock) begin
		if (state == state_idle && bus.job_valid) begin
			job      <= bus.job;
			rank_sum <= '0;
		end else if (state == state_reading && bus.response_valid) begin
			rank_sum <= rank_sum + bus.response_data;
		end
	end

	// The arbiter routes by tag, so an idle unit never owns a read
	assert property (@(posedge clock) disable iff (!rstn)
		bus.response_valid |-> (state != state_idle));

endmodule
